/* all.f */
hw/ex_pkg.sv
hw/ex_forward.sv
hw/ex_alu.sv
hw/ex_branch.sv
hw/ex_muldiv.sv
hw/ex_stage.sv
sim/ex_stage_props.sv
sim/tb_ex_stage.sv

/* hw/ex_alu.sv */
`timescale 1ns/1ps

module ex_alu
    import ex_pkg::*;
(
    input  logic [XLEN-1:0] op_a_i,
    input  logic [XLEN-1:0] op_b_i,
    input  alu_op_e         alu_op_i,
    output logic [XLEN-1:0] result_o
);

    logic               is_add;
    logic [XLEN-1:0]    b_eff;
    logic [XLEN:0]      sum;
    logic               lt_s;
    logic               lt_u;
    logic [SHAMT_W-1:0] shamt;

    //////////////////////////////////////////////////////////////////////
    // Shared adder
    //////////////////////////////////////////////////////////////////////

    // Everything except ADD subtracts so the compares can read the difference
    always_comb begin
        is_add = (alu_op_i == ALU_ADD);
        b_eff  = is_add ? op_b_i : ~op_b_i;
        sum    = {1'b0, op_a_i} + {1'b0, b_eff} + {{XLEN{1'b0}}, ~is_add};
        lt_u   = ~sum[XLEN];  // No carry out means borrow
        if (op_a_i[XLEN-1] != op_b_i[XLEN-1]) begin
            lt_s = op_a_i[XLEN-1];  // Signs differ
        end else begin
            lt_s = sum[XLEN-1];
        end
        shamt = op_b_i[SHAMT_W-1:0];
    end

    //////////////////////////////////////////////////////////////////////
    // Result select
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (alu_op_i)
            ALU_ADD,
            ALU_SUB:    result_o = sum[XLEN-1:0];
            ALU_AND:    result_o = op_a_i & op_b_i;
            ALU_OR:     result_o = op_a_i | op_b_i;
            ALU_XOR:    result_o = op_a_i ^ op_b_i;
            ALU_SLL:    result_o = op_a_i << shamt;
            ALU_SRL:    result_o = op_a_i >> shamt;
            ALU_SRA:    result_o = $signed(op_a_i) >>> shamt;
            ALU_SLT:    result_o = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU:   result_o = {{(XLEN-1){1'b0}}, lt_u};
            ALU_PASS_B: result_o = op_b_i;  // LUI
            default:    result_o = '0;
        endcase
    end

endmodule

/* hw/ex_branch.sv */
`timescale 1ns/1ps

module ex_branch
    import ex_pkg::*;
(
    input  logic [XLEN-1:0] rs1_i,
    input  logic [XLEN-1:0] rs2_i,
    input  logic [2:0]      funct3_i,
    input  logic            is_branch_i,
    input  logic            is_jump_i,
    output logic            pc_sel_o
);

    logic eq;
    logic lt_s;
    logic lt_u;
    logic taken;

    always_comb begin
        eq   = (rs1_i == rs2_i);
        lt_s = ($signed(rs1_i) < $signed(rs2_i));
        lt_u = (rs1_i < rs2_i);

        case (funct3_i)
            3'b000:  taken = eq;     // BEQ
            3'b001:  taken = ~eq;    // BNE
            3'b100:  taken = lt_s;   // BLT
            3'b101:  taken = ~lt_s;  // BGE
            3'b110:  taken = lt_u;   // BLTU
            3'b111:  taken = ~lt_u;  // BGEU
            default: taken = 1'b0;
        endcase

        pc_sel_o = is_jump_i | (is_branch_i & taken);
    end

endmodule

/* hw/ex_forward.sv */
`timescale 1ns/1ps

module ex_forward
    import ex_pkg::*;
(
    input  logic [REG_AW-1:0] rs1_label_i,
    input  logic [REG_AW-1:0] rs2_label_i,
    input  ex_mem_t           ex_mem_i,
    input  wb_fwd_t           wb_fwd_i,
    output fwd_sel_e          fwd_a_o,
    output fwd_sel_e          fwd_b_o
);

    // Newest producer of one source label
    function automatic fwd_sel_e pick_src(
        input logic [REG_AW-1:0] label,
        input ex_mem_t           exm,
        input wb_fwd_t           wb
    );
        fwd_sel_e sel;
        sel = FWD_REGFILE;
        if (label == '0) begin
            sel = FWD_REGFILE;  // x0 reads as zero
        end else if (exm.reg_wb_en && exm.rd == label) begin
            sel = FWD_EX_MEM;
        end else if (wb.reg_wb_en && wb.rd == label) begin
            sel = wb.is_load ? FWD_MEM_WB_LOAD : FWD_MEM_WB_ALU;
        end
        return sel;
    endfunction

    always_comb begin
        fwd_a_o = pick_src(rs1_label_i, ex_mem_i, wb_fwd_i);
        fwd_b_o = pick_src(rs2_label_i, ex_mem_i, wb_fwd_i);
    end

endmodule

/* hw/ex_muldiv.sv */
`timescale 1ns/1ps

module ex_muldiv
    import ex_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            req_i,
    input  logic [XLEN-1:0] op_a_i,
    input  logic [XLEN-1:0] op_b_i,
    input  mdu_op_e         mdu_op_i,
    output logic            ack_o,
    output logic [XLEN-1:0] result_o
);

    typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_FIX, ST_ACK} state_e;

    state_e                        state_q;
    logic [$clog2(MDU_CYCLES)-1:0] cnt_q;
    mdu_op_e                       op_q;
    logic                          neg_q;   // Result needs negation
    logic [XLEN-1:0]               hi_q;    // Product high half or remainder
    logic [XLEN-1:0]               lo_q;    // Multiplier or quotient
    logic [XLEN-1:0]               opb_q;   // Multiplicand or divisor
    logic [XLEN-1:0]               result_q;

    logic              a_neg;
    logic              b_neg;
    logic              start_neg;
    logic [XLEN-1:0]   a_mag;
    logic [XLEN-1:0]   b_mag;
    logic [XLEN:0]     mul_sum;
    logic [XLEN:0]     div_shift;
    logic [XLEN:0]     div_diff;
    logic [2*XLEN-1:0] prod_fix;
    logic [XLEN-1:0]   fix_val;

    //////////////////////////////////////////////////////////////////////
    // Operand magnitudes and one iteration step
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        a_neg = op_a_i[XLEN-1] & (mdu_op_i inside {MDU_MULH, MDU_MULHSU, MDU_DIV, MDU_REM});
        b_neg = op_b_i[XLEN-1] & (mdu_op_i inside {MDU_MULH, MDU_DIV, MDU_REM});
        a_mag = a_neg ? -op_a_i : op_a_i;
        b_mag = b_neg ? -op_b_i : op_b_i;
        if (!mdu_op_i[2]) begin
            start_neg = a_neg ^ b_neg;
        end else if (mdu_op_i[1]) begin
            start_neg = a_neg;  // Remainder takes the dividend sign
        end else begin
            start_neg = (a_neg ^ b_neg) & (|op_b_i);  // x/0 stays all ones
        end

        mul_sum   = {1'b0, hi_q} + {1'b0, (lo_q[0] ? opb_q : '0)};
        div_shift = {hi_q, lo_q[XLEN-1]};
        div_diff  = div_shift - {1'b0, opb_q};
    end

    // Sign fix-up and word select
    always_comb begin
        prod_fix = neg_q ? -{hi_q, lo_q} : {hi_q, lo_q};
        case (op_q)
            MDU_MUL:                         fix_val = prod_fix[XLEN-1:0];
            MDU_MULH, MDU_MULHSU, MDU_MULHU: fix_val = prod_fix[2*XLEN-1:XLEN];
            MDU_DIV, MDU_DIVU:               fix_val = neg_q ? -lo_q : lo_q;
            default:                         fix_val = neg_q ? -hi_q : hi_q;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Handshake FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
            ack_o   <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: if (req_i) begin
                    state_q <= ST_RUN;
                    cnt_q   <= '0;
                end
                ST_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == $bits(cnt_q)'(MDU_CYCLES - 1)) state_q <= ST_FIX;
                end
                ST_FIX: begin
                    state_q <= ST_ACK;
                    ack_o   <= 1'b1;
                end
                default: if (!req_i) begin  // Wait for req to fall
                    state_q <= ST_IDLE;
                    ack_o   <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && req_i) begin
            op_q  <= mdu_op_i;
            neg_q <= start_neg;
            hi_q  <= '0;
            lo_q  <= a_mag;
            opb_q <= b_mag;
        end else if (state_q == ST_RUN) begin
            if (op_q[2]) begin  // Restoring divide
                if (!div_diff[XLEN]) begin
                    hi_q <= div_diff[XLEN-1:0];
                    lo_q <= {lo_q[XLEN-2:0], 1'b1};
                end else begin
                    hi_q <= div_shift[XLEN-1:0];
                    lo_q <= {lo_q[XLEN-2:0], 1'b0};
                end
            end else begin  // Shift-add multiply
                hi_q <= mul_sum[XLEN:1];
                lo_q <= {mul_sum[0], lo_q[XLEN-1:1]};
            end
        end
        if (state_q == ST_FIX) result_q <= fix_val;
    end

    assign result_o = result_q;

endmodule

/* hw/ex_pkg.sv */
package ex_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    localparam int XLEN       = 32;
    localparam int REG_AW     = 5;
    localparam int SHAMT_W    = 5;   // Shift amount bits of op_b
    localparam int MDU_CYCLES = 32;  // One step per operand bit

    //////////////////////////////////////////////////////////////////////
    // Operation encodings
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASS_B
    } alu_op_e;

    // Same values as funct3 of the M extension
    typedef enum logic [2:0] {
        MDU_MUL, MDU_MULH, MDU_MULHSU, MDU_MULHU,
        MDU_DIV, MDU_DIVU, MDU_REM, MDU_REMU
    } mdu_op_e;

    typedef enum logic {UNIT_ALU, UNIT_MDU} unit_sel_e;

    typedef enum logic [1:0] {
        FWD_REGFILE, FWD_EX_MEM, FWD_MEM_WB_ALU, FWD_MEM_WB_LOAD
    } fwd_sel_e;

    //////////////////////////////////////////////////////////////////////
    // Pipeline payloads
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [REG_AW-1:0] rs1_label;
        logic [REG_AW-1:0] rs2_label;
        logic [XLEN-1:0]   rs1_value;
        logic [XLEN-1:0]   rs2_value;
        logic [XLEN-1:0]   imm;
        logic [REG_AW-1:0] rd;
        logic              reg_wb_en;
        logic [1:0]        wb_sel;
        logic              op1_pc;    // Operand A from PC
        logic              op2_imm;   // Operand B from immediate
        unit_sel_e         unit;
        alu_op_e           alu_op;
        mdu_op_e           mdu_op;
        logic [2:0]        funct3;
        logic              is_branch;
        logic              is_jump;
        logic              is_load;
        logic              is_store;
        logic [1:0]        mem_size;
    } ex_issue_t;

    typedef struct packed {
        logic [REG_AW-1:0] rd;
        logic              reg_wb_en;
        logic              is_load;
        logic [XLEN-1:0]   alu_result;
        logic [XLEN-1:0]   load_data;
    } wb_fwd_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [REG_AW-1:0] rd;
        logic              reg_wb_en;
        logic [1:0]        wb_sel;
        logic [XLEN-1:0]   result;
        logic [XLEN-1:0]   store_data;
        logic              pc_sel;
        logic              is_load;
        logic              is_store;
        logic [1:0]        mem_size;
        logic [2:0]        funct3;
    } ex_mem_t;

endpackage

/* hw/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage
    import ex_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      busywait_i,
    input  ex_issue_t issue_i,
    input  wb_fwd_t   wb_fwd_i,
    output ex_mem_t   ex_mem_o,
    output logic      stall_o
);

    typedef enum logic [1:0] {HS_IDLE, HS_BUSY, HS_DONE} hs_state_e;

    fwd_sel_e        fwd_a;
    fwd_sel_e        fwd_b;
    logic [XLEN-1:0] rs1_fwd;
    logic [XLEN-1:0] rs2_fwd;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_result;
    logic            pc_sel_w;

    hs_state_e       hs_state_q;
    hs_state_e       hs_state_d;
    logic            mdu_issue;
    logic            mdu_done;
    logic            mdu_start;
    logic            mdu_req;
    logic            mdu_ack;
    logic [XLEN-1:0] mdu_result;
    logic [XLEN-1:0] mdu_a_q;   // Held while req is up
    logic [XLEN-1:0] mdu_b_q;
    mdu_op_e         mdu_op_q;
    ex_mem_t         ex_mem_d;

    function automatic logic [XLEN-1:0] fwd_value(
        input fwd_sel_e        sel,
        input logic [XLEN-1:0] rf_val,
        input logic [XLEN-1:0] exm_val,
        input wb_fwd_t         wb
    );
        case (sel)
            FWD_EX_MEM:      return exm_val;
            FWD_MEM_WB_ALU:  return wb.alu_result;
            FWD_MEM_WB_LOAD: return wb.load_data;
            default:         return rf_val;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Operands
    //////////////////////////////////////////////////////////////////////

    ex_forward i_ex_forward (
        .rs1_label_i (issue_i.rs1_label),
        .rs2_label_i (issue_i.rs2_label),
        .ex_mem_i    (ex_mem_o),
        .wb_fwd_i    (wb_fwd_i),
        .fwd_a_o     (fwd_a),
        .fwd_b_o     (fwd_b)
    );

    always_comb begin
        rs1_fwd = fwd_value(fwd_a, issue_i.rs1_value, ex_mem_o.result, wb_fwd_i);
        rs2_fwd = fwd_value(fwd_b, issue_i.rs2_value, ex_mem_o.result, wb_fwd_i);
        op_a    = issue_i.op1_pc ? issue_i.pc : rs1_fwd;
        op_b    = issue_i.op2_imm ? issue_i.imm : rs2_fwd;
    end

    ex_alu i_ex_alu (
        .op_a_i   (op_a),
        .op_b_i   (op_b),
        .alu_op_i (issue_i.alu_op),
        .result_o (alu_result)
    );

    // Compares the register values, never the muxed operands
    ex_branch i_ex_branch (
        .rs1_i       (rs1_fwd),
        .rs2_i       (rs2_fwd),
        .funct3_i    (issue_i.funct3),
        .is_branch_i (issue_i.is_branch),
        .is_jump_i   (issue_i.is_jump),
        .pc_sel_o    (pc_sel_w)
    );

    //////////////////////////////////////////////////////////////////////
    // MDU req/ack control
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        mdu_issue = issue_i.valid && (issue_i.unit == UNIT_MDU);
        mdu_done  = (hs_state_q == HS_BUSY) && mdu_ack;
        // New req only from idle, or once the old ack has dropped
        mdu_start = mdu_issue && ((hs_state_q == HS_IDLE) ||
                                  (hs_state_q == HS_DONE && !mdu_ack));
        stall_o   = mdu_issue && !mdu_done;
        mdu_req   = (hs_state_q == HS_BUSY);

        hs_state_d = hs_state_q;
        case (hs_state_q)
            HS_IDLE: if (mdu_start) hs_state_d = HS_BUSY;
            HS_BUSY: if (mdu_ack) hs_state_d = HS_DONE;  // Capture and drop req
            default: if (!mdu_ack) hs_state_d = mdu_start ? HS_BUSY : HS_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            hs_state_q <= HS_IDLE;
        end else if (!busywait_i) begin
            hs_state_q <= hs_state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!busywait_i && mdu_start) begin
            mdu_a_q  <= op_a;
            mdu_b_q  <= op_b;
            mdu_op_q <= issue_i.mdu_op;
        end
    end

    ex_muldiv i_ex_muldiv (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .req_i    (mdu_req),
        .op_a_i   (mdu_a_q),
        .op_b_i   (mdu_b_q),
        .mdu_op_i (mdu_op_q),
        .ack_o    (mdu_ack),
        .result_o (mdu_result)
    );

    //////////////////////////////////////////////////////////////////////
    // EX/MEM register
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        ex_mem_d.valid      = issue_i.valid & ~stall_o;  // Bubble while stalled
        ex_mem_d.pc         = issue_i.pc;
        ex_mem_d.rd         = issue_i.rd;
        ex_mem_d.reg_wb_en  = issue_i.valid & issue_i.reg_wb_en & ~stall_o;
        ex_mem_d.wb_sel     = issue_i.wb_sel;
        ex_mem_d.result     = (issue_i.unit == UNIT_MDU) ? mdu_result : alu_result;
        ex_mem_d.store_data = rs2_fwd;
        ex_mem_d.pc_sel     = issue_i.valid & pc_sel_w & ~stall_o;
        ex_mem_d.is_load    = issue_i.valid & issue_i.is_load & ~stall_o;
        ex_mem_d.is_store   = issue_i.valid & issue_i.is_store & ~stall_o;
        ex_mem_d.mem_size   = issue_i.mem_size;
        ex_mem_d.funct3     = issue_i.funct3;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ex_mem_o.valid     <= 1'b0;
            ex_mem_o.reg_wb_en <= 1'b0;
            ex_mem_o.pc_sel    <= 1'b0;
            ex_mem_o.is_load   <= 1'b0;
            ex_mem_o.is_store  <= 1'b0;
        end else if (!busywait_i) begin  // Memory stall holds everything
            ex_mem_o <= ex_mem_d;
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# Compile and run the EX stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_ex_stage -f all.f -o tb_ex_stage
if [ $? -ne 0 ]; then
    echo "Compile failed"
    exit 1
fi

./obj_dir/tb_ex_stage > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "^Testbench passed$" sim.log; then
    exit 0
fi
exit 1

/* sim/ex_stage_props.sv */
`timescale 1ns/1ps

module ex_stage_props
    import ex_pkg::*;
(
    input logic    clk_i,
    input logic    rst_i,
    input logic    busywait_i,
    input logic    stall_o,
    input ex_mem_t ex_mem_o,
    input logic    mdu_req,
    input logic    mdu_ack
);

    int fail_cnt = 0;

    ////////////////////////////////////////////////////////////////////
    // Reset and pipeline hold
    ////////////////////////////////////////////////////////////////////

    assert property (@(posedge clk_i) rst_i |=> (!ex_mem_o.valid && !ex_mem_o.reg_wb_en &&
                                                 !ex_mem_o.pc_sel && !stall_o))
        else begin
            $error("EX/MEM not cleared by reset");
            fail_cnt++;
        end

    // Bubble while the MDU works
    assert property (@(posedge clk_i) disable iff (rst_i)
                     (stall_o && !busywait_i) |=> !ex_mem_o.reg_wb_en)
        else begin
            $error("Write enable set during stall");
            fail_cnt++;
        end

    assert property (@(posedge clk_i) disable iff (rst_i) busywait_i |=> $stable(ex_mem_o))
        else begin
            $error("EX/MEM changed under busywait");
            fail_cnt++;
        end

    ////////////////////////////////////////////////////////////////////
    // Four-phase req/ack order
    ////////////////////////////////////////////////////////////////////

    assert property (@(posedge clk_i) disable iff (rst_i) $rose(mdu_req) |-> !mdu_ack)
        else begin
            $error("req rose before ack fell");
            fail_cnt++;
        end

    assert property (@(posedge clk_i) disable iff (rst_i) $rose(mdu_ack) |-> mdu_req)
        else begin
            $error("ack rose without req");
            fail_cnt++;
        end

    assert property (@(posedge clk_i) disable iff (rst_i) (mdu_req && !mdu_ack) |=> mdu_req)
        else begin
            $error("req dropped before ack");
            fail_cnt++;
        end

    assert property (@(posedge clk_i) disable iff (rst_i) (mdu_ack && mdu_req) |=> mdu_ack)
        else begin
            $error("ack dropped while req high");
            fail_cnt++;
        end

endmodule

bind ex_stage ex_stage_props i_ex_stage_props (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .busywait_i (busywait_i),
    .stall_o    (stall_o),
    .ex_mem_o   (ex_mem_o),
    .mdu_req    (mdu_req),
    .mdu_ack    (mdu_ack)
);

/* sim/tb_ex_stage.sv */
`timescale 1ns/1ps

module tb_ex_stage
    import ex_pkg::*;
;

    localparam int N_INSTR     = 67;
    localparam int TIMEOUT_CYC = N_INSTR * (MDU_CYCLES + 6) + 20;

    logic      clk_i = 1'b0;
    logic      rst_i;
    logic      busywait_i;
    ex_issue_t issue_i;
    wb_fwd_t   wb_fwd_i;
    ex_mem_t   ex_mem_o;
    logic      stall_o;

    int              errors;
    logic [31:0]     rng;
    logic            prev_wb;    // Model of the EX/MEM producer
    logic [REG_AW-1:0] prev_rd;
    logic [XLEN-1:0] prev_res;

    always #50 clk_i = ~clk_i;

    ex_stage i_ex_stage (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .busywait_i (busywait_i),
        .issue_i    (issue_i),
        .wb_fwd_i   (wb_fwd_i),
        .ex_mem_o   (ex_mem_o),
        .stall_o    (stall_o)
    );

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    ////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////

    // Newest value of a source register with EX/MEM ahead of MEM/WB
    function automatic logic [XLEN-1:0] resolve(input logic [REG_AW-1:0] label,
                                                input logic [XLEN-1:0] rf_val);
        if (label == '0) return rf_val;
        if (prev_wb && prev_rd == label) return prev_res;
        if (wb_fwd_i.reg_wb_en && wb_fwd_i.rd == label) begin
            return wb_fwd_i.is_load ? wb_fwd_i.load_data : wb_fwd_i.alu_result;
        end
        return rf_val;
    endfunction

    function automatic logic [XLEN-1:0] alu_model(input alu_op_e op,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: return {31'b0, a < b};
            default:  return b;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] mdu_model(input mdu_op_e op,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] ub;
        logic [63:0]        uprod;
        logic               ovf;
        sa    = {{32{a[31]}}, a};
        sb    = {{32{b[31]}}, b};
        ub    = {32'b0, b};
        uprod = {32'b0, a} * {32'b0, b};
        ovf   = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (op)
            MDU_MUL:    return uprod[31:0];
            MDU_MULH:   return 32'((sa * sb) >>> 32);
            MDU_MULHSU: return 32'((sa * ub) >>> 32);
            MDU_MULHU:  return uprod[63:32];
            MDU_DIV:    return (b == 0) ? 32'hffff_ffff : ovf ? a :
                               32'($signed(a) / $signed(b));
            MDU_DIVU:   return (b == 0) ? 32'hffff_ffff : a / b;
            MDU_REM:    return (b == 0) ? a : ovf ? 32'h0 : 32'($signed(a) % $signed(b));
            default:    return (b == 0) ? a : a % b;
        endcase
    endfunction

    function automatic logic branch_model(input logic [2:0] f3,
                                          input logic [XLEN-1:0] a,
                                          input logic [XLEN-1:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
        assert (got === exp) else begin
            errors++;
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    function automatic ex_issue_t rand_issue();
        ex_issue_t   ins;
        logic [31:0] side;
        ins           = '0;
        ins.valid     = 1'b1;
        ins.pc        = next_rand() & 32'hffff_fffc;
        ins.rs1_label = 5'(next_rand() & 3);  // Few labels so hazards are common
        ins.rs2_label = 5'(next_rand() & 3);
        ins.rs1_value = next_rand();
        ins.rs2_value = next_rand();
        ins.imm       = next_rand();
        ins.rd        = 5'(next_rand() & 3);
        ins.reg_wb_en = 1'b1;
        side          = next_rand();  // Fields that only pass through
        ins.wb_sel    = side[1:0];
        ins.mem_size  = side[3:2];
        ins.is_load   = side[4];
        ins.is_store  = side[5];
        ins.funct3    = side[8:6];
        return ins;
    endfunction

    // Issue one instruction at a falling edge and check its EX/MEM entry
    task automatic run_instr(input ex_issue_t ins, input int hold);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] exp;
        logic            exp_sel;
        wb_fwd_i.rd         = 5'(next_rand() & 3);
        wb_fwd_i.reg_wb_en  = rng[7];
        wb_fwd_i.is_load    = rng[9];
        wb_fwd_i.alu_result = next_rand();
        wb_fwd_i.load_data  = next_rand();
        a       = resolve(ins.rs1_label, ins.rs1_value);
        b       = resolve(ins.rs2_label, ins.rs2_value);
        exp_sel = ins.is_jump | (ins.is_branch & branch_model(ins.funct3, a, b));
        if (ins.unit == UNIT_MDU) begin
            exp = mdu_model(ins.mdu_op, a, b);
        end else begin
            exp = alu_model(ins.alu_op, ins.op1_pc ? ins.pc : a, ins.op2_imm ? ins.imm : b);
        end
        issue_i = ins;
        #1;
        while (stall_o) begin
            @(negedge clk_i);
            check_val("ex_mem_o.reg_wb_en", 32'(0), 32'(ex_mem_o.reg_wb_en));
            #1;
        end
        if (hold > 0) begin
            busywait_i = 1'b1;
            repeat (hold) @(negedge clk_i);
            busywait_i = 1'b0;
        end
        @(negedge clk_i);
        check_val("ex_mem_o.valid", 32'(1), 32'(ex_mem_o.valid));
        check_val("ex_mem_o.result", exp, ex_mem_o.result);
        check_val("ex_mem_o.pc_sel", 32'(exp_sel), 32'(ex_mem_o.pc_sel));
        check_val("ex_mem_o.reg_wb_en", 32'(ins.reg_wb_en), 32'(ex_mem_o.reg_wb_en));
        check_val("ex_mem_o.pc", ins.pc, ex_mem_o.pc);
        check_val("ex_mem_o.rd", 32'(ins.rd), 32'(ex_mem_o.rd));
        check_val("ex_mem_o.wb_sel", 32'(ins.wb_sel), 32'(ex_mem_o.wb_sel));
        check_val("ex_mem_o.is_load", 32'(ins.is_load), 32'(ex_mem_o.is_load));
        check_val("ex_mem_o.is_store", 32'(ins.is_store), 32'(ex_mem_o.is_store));
        check_val("ex_mem_o.mem_size", 32'(ins.mem_size), 32'(ex_mem_o.mem_size));
        check_val("ex_mem_o.funct3", 32'(ins.funct3), 32'(ex_mem_o.funct3));
        if (ins.unit == UNIT_ALU) check_val("ex_mem_o.store_data", b, ex_mem_o.store_data);
        prev_wb  = ins.reg_wb_en;
        prev_rd  = ins.rd;
        prev_res = exp;
    endtask

    task automatic run_mdu(input mdu_op_e op, input logic [XLEN-1:0] a,
                           input logic [XLEN-1:0] b);
        ex_issue_t ins;
        ins           = rand_issue();
        ins.rs1_label = '0;  // Operands straight from the register file
        ins.rs2_label = '0;
        ins.rs1_value = a;
        ins.rs2_value = b;
        ins.unit      = UNIT_MDU;
        ins.mdu_op    = op;
        run_instr(ins, 0);
    endtask

    ////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////

    initial begin
        ex_issue_t    ins;
        logic [2:0]   f3_list [6];
        f3_list    = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        errors     = 0;
        rng        = 32'd65;
        prev_wb    = 1'b0;
        prev_rd    = '0;
        prev_res   = '0;
        rst_i      = 1'b1;
        busywait_i = 1'b0;
        issue_i    = '0;
        wb_fwd_i   = '0;
        repeat (5) @(negedge clk_i);
        rst_i = 1'b0;

        for (int i = 0; i < 40; i++) begin
            ins         = rand_issue();
            ins.alu_op  = alu_op_e'(4'(next_rand() % 11));
            ins.op2_imm = rng[3];
            ins.op1_pc  = (i % 7 == 0);
            run_instr(ins, (i == 20 || i == 31) ? 3 : 0);
        end

        // Each condition once with equal and once with random values
        for (int k = 0; k < 12; k++) begin
            ins           = rand_issue();
            ins.reg_wb_en = 1'b0;
            ins.is_branch = 1'b1;
            ins.funct3    = f3_list[k % 6];
            if (k < 6) ins.rs2_value = ins.rs1_value;
            run_instr(ins, 0);
        end
        ins         = rand_issue();
        ins.is_jump = 1'b1;
        run_instr(ins, 0);

        for (int m = 0; m < 8; m++) run_mdu(mdu_op_e'(m), next_rand(), next_rand());
        run_mdu(MDU_DIV, next_rand(), 32'h0);
        run_mdu(MDU_DIVU, next_rand(), 32'h0);
        run_mdu(MDU_REM, next_rand(), 32'h0);
        run_mdu(MDU_REMU, next_rand(), 32'h0);
        run_mdu(MDU_DIV, 32'h8000_0000, 32'hffff_ffff);
        run_mdu(MDU_REM, 32'h8000_0000, 32'hffff_ffff);

        issue_i = '0;
        repeat (3) @(negedge clk_i);
        $display("Value errors: %0d, property failures: %0d",
                 errors, i_ex_stage.i_ex_stage_props.fail_cnt);
        if (errors == 0 && i_ex_stage.i_ex_stage_props.fail_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk_i);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
        $display("Testbench failed");
        $finish;
    end

endmodule
